// File: common/lc4_isa_pkg.sv
`default_nettype none

package lc4_isa_pkg;

  localparam int WORD_W    = 16;  // Data, address and instruction width
  localparam int REG_SEL_W = 3;
  localparam int NUM_REGS  = 8;
  localparam int NZP_W     = 3;
  localparam int OPCODE_W  = 4;   // Insn bits 15:12
  localparam int IMM5_W    = 5;   // ADD and AND immediate
  localparam int IMM6_W    = 6;   // LDR and STR offset
  localparam int IMM9_W    = 9;   // BR offset and CONST value

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_SEL_W-1:0] reg_sel_t;
  typedef logic [NZP_W-1:0]     nzp_t;  // Bit 2 is N, bit 1 is Z, bit 0 is P

  // Subset of the LC4 opcode map
  typedef enum logic [OPCODE_W-1:0] {
    OP_BR    = 4'h0,
    OP_ARITH = 4'h1,  // ADD and SUB, register or imm5
    OP_AND   = 4'h5,
    OP_LDR   = 4'h6,
    OP_STR   = 4'h7,
    OP_CONST = 4'h9
  } opcode_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_PASS_IMM,
    ALU_ADD_PC  // Branch target, PC + 1 + imm
  } alu_op_t;

  // Condition codes of a value written to the register file
  function automatic nzp_t nzp_of(input word_t value);
    nzp_t nzp;
    nzp[2] = value[WORD_W-1];
    nzp[1] = (value == '0);
    nzp[0] = !value[WORD_W-1] && (value != '0);
    return nzp;
  endfunction

endpackage

`default_nettype wire

// File: common/lc4_pipe_pkg.sv
`default_nettype none

package lc4_pipe_pkg;

  // Source of an execute-stage operand
  typedef enum logic [1:0] {
    FWD_REGFILE,   // Value read in decode
    FWD_FROM_MEM,  // ALU result of the insn in memory
    FWD_FROM_WB    // Value being written back
  } fwd_sel_t;

  // BR with mask 000, never taken
  localparam lc4_isa_pkg::word_t BUBBLE_INSN = '0;

  localparam lc4_isa_pkg::nzp_t NZP_RESET = 3'b010;  // Z set

endpackage

`default_nettype wire

// File: design/lc4_core.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_core #(
  parameter lc4_isa_pkg::word_t P_RESET_PC = 16'h8200
) (
  input  wire logic                  gwe,
  input  wire logic                  i_rst_n,
  output lc4_isa_pkg::word_t         o_imem_addr,
  input  wire lc4_isa_pkg::word_t    i_imem_data,   // Same-cycle fetch
  output lc4_isa_pkg::word_t         o_dmem_addr,
  output logic                       o_dmem_we,
  output lc4_isa_pkg::word_t         o_dmem_wdata,
  input  wire lc4_isa_pkg::word_t    i_dmem_rdata,  // Same-cycle load
  output logic                       o_wb_we,       // Write trace
  output lc4_isa_pkg::reg_sel_t      o_wb_sel,
  output lc4_isa_pkg::word_t         o_wb_data
);

  lc4_isa_pkg::word_t     pc, d_insn, d_pc, d_imm, d_rs_data, d_rt_data;
  lc4_isa_pkg::reg_sel_t  d_rs, d_rt, d_rd;
  logic                   d_rs_re, d_rt_re, d_reg_we, d_is_load, d_is_store, d_is_branch;
  lc4_isa_pkg::alu_op_t   d_alu_op;
  lc4_isa_pkg::word_t     x_insn, x_pc, x_imm, x_rs_data, x_rt_data, alu_a, alu_b, x_result;
  lc4_isa_pkg::reg_sel_t  x_rs, x_rt, x_rd;
  logic                   x_reg_we, x_is_load, x_is_store, x_is_branch, x_use_imm;
  lc4_isa_pkg::alu_op_t   x_alu_op;
  lc4_isa_pkg::word_t     m_alu, m_store_data, m_wb_data;
  lc4_isa_pkg::reg_sel_t  m_rd, m_rt;
  logic                   m_reg_we, m_is_load, m_is_store;
  lc4_isa_pkg::word_t     w_wdata;
  lc4_isa_pkg::reg_sel_t  w_rd;
  logic                   w_reg_we;
  lc4_isa_pkg::nzp_t      nzp_reg;
  logic                   stall, flush, fwd_store;
  lc4_pipe_pkg::fwd_sel_t fwd_a, fwd_b;

  function automatic lc4_isa_pkg::word_t fwd_mux(input lc4_pipe_pkg::fwd_sel_t sel,
      input lc4_isa_pkg::word_t rf, input lc4_isa_pkg::word_t mem,
      input lc4_isa_pkg::word_t wb);
    case (sel)
      lc4_pipe_pkg::FWD_FROM_MEM: return mem;
      lc4_pipe_pkg::FWD_FROM_WB:  return wb;
      default:                    return rf;
    endcase
  endfunction

  lc4_fetch #(.P_RESET_PC(P_RESET_PC)) u_lc4_fetch (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_stall(stall), .i_redirect(flush),
    .i_target(x_result), .o_pc(pc)
  );
  assign o_imem_addr = pc;

  // Fetch/decode register, bubble on flush, hold on stall
  always_ff @(posedge gwe) begin
    if (!i_rst_n || flush) d_insn <= lc4_pipe_pkg::BUBBLE_INSN;
    else if (!stall) d_insn <= i_imem_data;
  end
  always_ff @(posedge gwe) if (!stall) d_pc <= pc;

  lc4_decoder u_lc4_decoder (
    .i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_rd(d_rd),
    .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_reg_we(d_reg_we),
    .o_is_load(d_is_load), .o_is_store(d_is_store), .o_is_branch(d_is_branch),
    .o_alu_op(d_alu_op), .o_imm(d_imm)
  );

  lc4_regfile u_lc4_regfile (
    .gwe(gwe), .i_rst_n(i_rst_n), .i_rs(d_rs), .i_rt(d_rt), .i_rd(w_rd),
    .i_we(w_reg_we), .i_wdata(w_wdata), .o_rs_data(d_rs_data), .o_rt_data(d_rt_data)
  );

  // Decode/execute register, flush or load-use stall leaves a bubble
  always_ff @(posedge gwe) begin
    if (!i_rst_n || flush || stall) begin
      x_insn      <= lc4_pipe_pkg::BUBBLE_INSN;
      x_reg_we    <= 1'b0;
      x_is_load   <= 1'b0;
      x_is_store  <= 1'b0;
      x_is_branch <= 1'b0;
    end else begin
      x_insn      <= d_insn;
      x_reg_we    <= d_reg_we;
      x_is_load   <= d_is_load;
      x_is_store  <= d_is_store;
      x_is_branch <= d_is_branch;
    end
  end
  always_ff @(posedge gwe) begin
    x_pc      <= d_pc;
    x_rs      <= d_rs;
    x_rt      <= d_rt;
    x_rd      <= d_rd;
    x_imm     <= d_imm;
    x_alu_op  <= d_alu_op;
    x_use_imm <= !d_rt_re || d_is_store;  // Store adds imm6, rt is only data
    x_rs_data <= d_rs_data;
    x_rt_data <= d_rt_data;
  end

  // Operands with forwarding, memory path carries the ALU result only
  assign alu_a = fwd_mux(fwd_a, x_rs_data, m_alu, w_wdata);
  assign alu_b = fwd_mux(fwd_b, x_rt_data, m_alu, w_wdata);

  lc4_alu u_lc4_alu (
    .i_op(x_alu_op), .i_a(alu_a), .i_b(alu_b), .i_imm(x_imm), .i_pc(x_pc),
    .i_use_imm(x_use_imm), .o_result(x_result)
  );

  lc4_hazard_unit u_lc4_hazard_unit (
    .i_d_rs(d_rs), .i_d_rt(d_rt), .i_x_rd(x_rd), .i_m_rd(m_rd), .i_w_rd(w_rd),
    .i_x_rs(x_rs), .i_x_rt(x_rt), .i_m_rt(m_rt),
    .i_d_rs_re(d_rs_re),
    .i_d_rt_re(d_rt_re && !d_is_store),  // Store data is patched in memory instead
    .i_x_is_load(x_is_load), .i_m_reg_we(m_reg_we), .i_w_reg_we(w_reg_we),
    .i_x_is_branch(x_is_branch), .i_x_nzp_mask(x_insn[11:9]), .i_nzp_reg(nzp_reg),
    .i_m_result(m_wb_data), .i_w_result(w_wdata),
    .o_stall(stall), .o_flush(flush), .o_fwd_a(fwd_a), .o_fwd_b(fwd_b),
    .o_fwd_store(fwd_store)
  );

  // Execute/memory register
  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      m_reg_we   <= 1'b0;
      m_is_load  <= 1'b0;
      m_is_store <= 1'b0;
    end else begin
      m_reg_we   <= x_reg_we;
      m_is_load  <= x_is_load;
      m_is_store <= x_is_store;
    end
  end
  always_ff @(posedge gwe) begin
    m_rd         <= x_rd;
    m_rt         <= x_rt;
    m_alu        <= x_result;
    m_store_data <= alu_b;
  end

  assign o_dmem_addr  = m_alu;  // rs + imm6
  assign o_dmem_we    = m_is_store;
  assign o_dmem_wdata = fwd_store ? w_wdata : m_store_data;
  assign m_wb_data    = m_is_load ? i_dmem_rdata : m_alu;

  // Memory/writeback register
  always_ff @(posedge gwe) begin
    if (!i_rst_n) w_reg_we <= 1'b0;
    else w_reg_we <= m_reg_we;
  end
  always_ff @(posedge gwe) begin
    w_rd    <= m_rd;
    w_wdata <= m_wb_data;
  end

  // Every register write also sets NZP
  always_ff @(posedge gwe) begin
    if (!i_rst_n) nzp_reg <= lc4_pipe_pkg::NZP_RESET;
    else if (w_reg_we) nzp_reg <= lc4_isa_pkg::nzp_of(w_wdata);
  end

  assign o_wb_we   = w_reg_we;
  assign o_wb_sel  = w_rd;
  assign o_wb_data = w_wdata;

endmodule

`default_nettype wire

// File: design/lc4_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_decoder (
  input  wire lc4_isa_pkg::word_t  i_insn,
  output lc4_isa_pkg::reg_sel_t    o_rs,
  output lc4_isa_pkg::reg_sel_t    o_rt,
  output lc4_isa_pkg::reg_sel_t    o_rd,
  output logic                     o_rs_re,
  output logic                     o_rt_re,
  output logic                     o_reg_we,
  output logic                     o_is_load,
  output logic                     o_is_store,
  output logic                     o_is_branch,
  output lc4_isa_pkg::alu_op_t     o_alu_op,
  output lc4_isa_pkg::word_t       o_imm
);

  lc4_isa_pkg::opcode_t opcode;
  lc4_isa_pkg::word_t   imm5_sx, imm6_sx, imm9_sx;

  assign opcode  = lc4_isa_pkg::opcode_t'(i_insn[15:12]);
  // Sign-extended immediates, all start at bit 0
  assign imm5_sx = {{(lc4_isa_pkg::WORD_W - lc4_isa_pkg::IMM5_W){i_insn[4]}}, i_insn[4:0]};
  assign imm6_sx = {{(lc4_isa_pkg::WORD_W - lc4_isa_pkg::IMM6_W){i_insn[5]}}, i_insn[5:0]};
  assign imm9_sx = {{(lc4_isa_pkg::WORD_W - lc4_isa_pkg::IMM9_W){i_insn[8]}}, i_insn[8:0]};

  always_comb begin
    o_rs        = i_insn[8:6];
    o_rt        = i_insn[2:0];
    o_rd        = i_insn[11:9];
    o_rs_re     = 1'b0;  // Everything off unless the opcode is known
    o_rt_re     = 1'b0;
    o_reg_we    = 1'b0;
    o_is_load   = 1'b0;
    o_is_store  = 1'b0;
    o_is_branch = 1'b0;
    o_alu_op    = lc4_isa_pkg::ALU_ADD;
    o_imm       = '0;
    case (opcode)
      lc4_isa_pkg::OP_BR: begin
        o_is_branch = (i_insn[11:9] != 3'b000);  // Mask 000 is the NOP
        o_alu_op    = lc4_isa_pkg::ALU_ADD_PC;
        o_imm       = imm9_sx;
      end
      lc4_isa_pkg::OP_ARITH: begin
        if (i_insn[5]) begin  // ADD imm5
          o_rs_re  = 1'b1;
          o_reg_we = 1'b1;
          o_imm    = imm5_sx;
        end else if (i_insn[3] == 1'b0) begin  // Subop 00 ADD, 10 SUB, MUL and DIV dropped
          o_rs_re  = 1'b1;
          o_rt_re  = 1'b1;
          o_reg_we = 1'b1;
          o_alu_op = i_insn[4] ? lc4_isa_pkg::ALU_SUB : lc4_isa_pkg::ALU_ADD;
        end
      end
      lc4_isa_pkg::OP_AND: begin
        if (i_insn[5] || i_insn[4:3] == 2'b00) begin  // NOT, OR, XOR fall out
          o_rs_re  = 1'b1;
          o_rt_re  = !i_insn[5];
          o_reg_we = 1'b1;
          o_alu_op = lc4_isa_pkg::ALU_AND;
          o_imm    = imm5_sx;
        end
      end
      lc4_isa_pkg::OP_LDR: begin
        o_rs_re   = 1'b1;
        o_reg_we  = 1'b1;
        o_is_load = 1'b1;
        o_imm     = imm6_sx;  // Address is rs + imm6
      end
      lc4_isa_pkg::OP_STR: begin
        o_rt       = i_insn[11:9];  // Store data sits in the rd field
        o_rs_re    = 1'b1;
        o_rt_re    = 1'b1;
        o_is_store = 1'b1;
        o_imm      = imm6_sx;
      end
      lc4_isa_pkg::OP_CONST: begin
        o_reg_we = 1'b1;
        o_alu_op = lc4_isa_pkg::ALU_PASS_IMM;
        o_imm    = imm9_sx;
      end
      default: ;  // Unsupported, NOP
    endcase
  end

endmodule

`default_nettype wire

// File: design/lc4_fetch.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_fetch #(
  parameter lc4_isa_pkg::word_t P_RESET_PC = 16'h8200
) (
  input  wire logic               gwe,
  input  wire logic               i_rst_n,
  input  wire logic               i_stall,     // Load-use hold
  input  wire logic               i_redirect,  // Taken branch in execute
  input  wire lc4_isa_pkg::word_t i_target,
  output lc4_isa_pkg::word_t      o_pc
);

  lc4_isa_pkg::word_t pc_q;
  lc4_isa_pkg::word_t pc_inc;

  assign pc_inc = pc_q + 16'd1;  // Sequential fetch

  // Redirect wins over stall, the held insn is flushed anyway
  always_ff @(posedge gwe) begin
    if (!i_rst_n) pc_q <= P_RESET_PC;
    else if (i_redirect) pc_q <= i_target;
    else if (!i_stall) pc_q <= pc_inc;
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

// File: design/lc4_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_regfile (
  input  wire logic                  gwe,
  input  wire logic                  i_rst_n,
  input  wire lc4_isa_pkg::reg_sel_t i_rs,
  input  wire lc4_isa_pkg::reg_sel_t i_rt,
  input  wire lc4_isa_pkg::reg_sel_t i_rd,
  input  wire logic                  i_we,
  input  wire lc4_isa_pkg::word_t    i_wdata,
  output lc4_isa_pkg::word_t         o_rs_data,
  output lc4_isa_pkg::word_t         o_rt_data
);

  lc4_isa_pkg::word_t regs [lc4_isa_pkg::NUM_REGS];

  always_ff @(posedge gwe) begin
    if (!i_rst_n) begin
      for (int i = 0; i < lc4_isa_pkg::NUM_REGS; i++) regs[i] <= '0;
    end else if (i_we) begin
      regs[i_rd] <= i_wdata;
    end
  end

  // Writeback value shows up in decode in the same cycle
  assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
  assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

// File: execute/lc4_alu.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_alu (
  input  wire lc4_isa_pkg::alu_op_t i_op,
  input  wire lc4_isa_pkg::word_t   i_a,
  input  wire lc4_isa_pkg::word_t   i_b,
  input  wire lc4_isa_pkg::word_t   i_imm,
  input  wire lc4_isa_pkg::word_t   i_pc,
  input  wire logic                 i_use_imm,  // imm replaces rt
  output lc4_isa_pkg::word_t        o_result
);

  lc4_isa_pkg::word_t b_op, add_a, add_b, sum;
  logic               cin;

  always_comb begin
    b_op  = i_use_imm ? i_imm : i_b;
    add_a = i_a;
    add_b = b_op;
    cin   = 1'b0;
    if (i_op == lc4_isa_pkg::ALU_SUB) begin  // a + ~b + 1
      add_b = ~b_op;
      cin   = 1'b1;
    end else if (i_op == lc4_isa_pkg::ALU_ADD_PC) begin  // PC + 1 + imm9
      add_a = i_pc;
      add_b = i_imm;
      cin   = 1'b1;
    end
    sum = add_a + add_b + lc4_isa_pkg::word_t'(cin);  // One adder for all sums
    case (i_op)
      lc4_isa_pkg::ALU_AND:      o_result = i_a & b_op;
      lc4_isa_pkg::ALU_PASS_IMM: o_result = i_imm;  // CONST
      default:                   o_result = sum;    // ADD, SUB, addresses, targets
    endcase
  end

endmodule

`default_nettype wire

// File: execute/lc4_hazard_unit.sv
`timescale 1ns/1ns
`default_nettype none

module lc4_hazard_unit (
  input  wire lc4_isa_pkg::reg_sel_t i_d_rs,
  input  wire lc4_isa_pkg::reg_sel_t i_d_rt,
  input  wire lc4_isa_pkg::reg_sel_t i_x_rd,
  input  wire lc4_isa_pkg::reg_sel_t i_m_rd,
  input  wire lc4_isa_pkg::reg_sel_t i_w_rd,
  input  wire lc4_isa_pkg::reg_sel_t i_x_rs,
  input  wire lc4_isa_pkg::reg_sel_t i_x_rt,
  input  wire lc4_isa_pkg::reg_sel_t i_m_rt,
  input  wire logic                  i_d_rs_re,
  input  wire logic                  i_d_rt_re,
  input  wire logic                  i_x_is_load,
  input  wire logic                  i_m_reg_we,
  input  wire logic                  i_w_reg_we,
  input  wire logic                  i_x_is_branch,
  input  wire lc4_isa_pkg::nzp_t     i_x_nzp_mask,
  input  wire lc4_isa_pkg::nzp_t     i_nzp_reg,
  input  wire lc4_isa_pkg::word_t    i_m_result,  // Memory-stage writeback value
  input  wire lc4_isa_pkg::word_t    i_w_result,
  output logic                       o_stall,
  output logic                       o_flush,
  output lc4_pipe_pkg::fwd_sel_t     o_fwd_a,
  output lc4_pipe_pkg::fwd_sel_t     o_fwd_b,
  output logic                       o_fwd_store
);

  lc4_isa_pkg::nzp_t cur_nzp;

  // Newest older writer of a register, memory before writeback
  function automatic lc4_pipe_pkg::fwd_sel_t pick_src(input lc4_isa_pkg::reg_sel_t src);
    if (i_m_reg_we && i_m_rd == src) return lc4_pipe_pkg::FWD_FROM_MEM;
    if (i_w_reg_we && i_w_rd == src) return lc4_pipe_pkg::FWD_FROM_WB;
    return lc4_pipe_pkg::FWD_REGFILE;
  endfunction

  // Load data is not ready for an execute-stage user one cycle behind
  assign o_stall = i_x_is_load && ((i_d_rs_re && i_d_rs == i_x_rd) ||
                                   (i_d_rt_re && i_d_rt == i_x_rd));

  always_comb begin
    o_fwd_a = pick_src(i_x_rs);
    o_fwd_b = pick_src(i_x_rt);
  end

  // Store data from a load right ahead of it
  assign o_fwd_store = i_w_reg_we && (i_w_rd == i_m_rt);

  // NZP as the branch in execute should see it
  always_comb begin
    if (i_m_reg_we) cur_nzp = lc4_isa_pkg::nzp_of(i_m_result);
    else if (i_w_reg_we) cur_nzp = lc4_isa_pkg::nzp_of(i_w_result);
    else cur_nzp = i_nzp_reg;
  end

  assign o_flush = i_x_is_branch && ((i_x_nzp_mask & cur_nzp) != '0);  // Taken

endmodule

`default_nettype wire

// File: lc4_core.f
+incdir+tests
common/lc4_isa_pkg.sv
common/lc4_pipe_pkg.sv
design/lc4_fetch.sv
design/lc4_decoder.sv
design/lc4_regfile.sv
execute/lc4_alu.sv
execute/lc4_hazard_unit.sv
design/lc4_core.sv
tests/tb_lc4_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the lc4_core testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_lc4_core -f lc4_core.f \
  --Mdir "$BUILD_DIR" -o tb_lc4_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_lc4_core" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation run returned an error status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: tests/lc4_programs.svh
`ifndef LC4_PROGRAMS_SVH
`define LC4_PROGRAMS_SVH

// One row per test, programs load at the reset PC and run out into NOPs
localparam int NUM_TESTS = 6;
localparam int MAX_PROG  = 13;
localparam int MAX_INIT  = 2;
localparam int MAX_WR    = 7;
localparam int MAX_ST    = 2;

localparam logic [15:0] PROG [0:NUM_TESTS-1][0:MAX_PROG-1] = '{
  '{16'h9205, 16'h95FD, 16'h1642, 16'h18D1, 16'h1B27, 16'h5D44, 16'h5EBE,  // ALU chain
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h9220, 16'h6440, 16'h16A1, 16'h6841, 16'h5B02, 16'h0000, 16'h0000,  // Load-use
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h9230, 16'h94AB, 16'h7442, 16'h6642, 16'h7643, 16'h6A43, 16'h0000,  // Store then load
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  '{16'h9200, 16'h0802, 16'h95FF, 16'h0802, 16'h9601, 16'h9802, 16'h9A03,  // Branches
    16'h0C01, 16'h1D64, 16'h0202, 16'h9E05, 16'h9E06, 16'h1F86},
  '{16'h9205, 16'h95FD, 16'h1642, 16'h18D1, 16'h1B27, 16'h5D44, 16'h5EBE,  // Mid reset
    16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
  // BRn sees the writer in writeback, BRp sees only the NZP register
  '{16'h93FF, 16'h9401, 16'h0000, 16'h0802, 16'h9606, 16'h0000, 16'h0000,
    16'h0202, 16'h9805, 16'h9A05, 16'h9C07, 16'h0000, 16'h0000}
};

// Initial data words as {addr, data}
localparam logic [31:0] INIT [0:NUM_TESTS-1][0:MAX_INIT-1] = '{
  '{32'h0, 32'h0}, '{32'h0020_1234, 32'h0021_00F0}, '{32'h0032_DEAD, 32'h0},
  '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'h0, 32'h0}
};
localparam int N_INIT [0:NUM_TESTS-1] = '{0, 2, 1, 0, 0, 0};

// Register writes in program order as {sel, data}
localparam logic [19:0] WR [0:NUM_TESTS-1][0:MAX_WR-1] = '{
  '{20'h1_0005, 20'h2_FFFD, 20'h3_0002, 20'h4_FFFD, 20'h5_0004, 20'h6_0004, 20'h7_FFFC},
  '{20'h1_0020, 20'h2_1234, 20'h3_1235, 20'h4_00F0, 20'h5_0030, 20'h0, 20'h0},
  '{20'h1_0030, 20'h2_00AB, 20'h3_00AB, 20'h5_00AB, 20'h0, 20'h0, 20'h0},
  '{20'h1_0000, 20'h2_FFFF, 20'h5_0003, 20'h6_0007, 20'h7_000E, 20'h0, 20'h0},
  '{20'h1_0005, 20'h2_FFFD, 20'h3_0002, 20'h4_FFFD, 20'h5_0004, 20'h6_0004, 20'h7_FFFC},
  '{20'h1_FFFF, 20'h2_0001, 20'h3_0006, 20'h6_0007, 20'h0, 20'h0, 20'h0}
};
localparam int N_WR [0:NUM_TESTS-1] = '{7, 5, 4, 5, 7, 4};

// Stores as {addr, data}
localparam logic [31:0] ST [0:NUM_TESTS-1][0:MAX_ST-1] = '{
  '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'h0032_00AB, 32'h0033_00AB},
  '{32'h0, 32'h0}, '{32'h0, 32'h0}, '{32'h0, 32'h0}
};
localparam int N_ST [0:NUM_TESTS-1] = '{0, 0, 2, 0, 0, 0};

localparam int RESET_AFTER [0:NUM_TESTS-1] = '{0, 0, 0, 0, 3, 0};  // Writes before a reset pulse

`endif

// File: tests/tb_lc4_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lc4_core;

  localparam logic [15:0] RESET_PC = 16'h8200;
  localparam int RESET_CYCLES = 8;
  localparam int WAIT_LIMIT   = 200;  // Cycles per wait
  localparam int DRAIN_CYCLES = 10;   // Room for stray writes after the last one

  `include "lc4_programs.svh"

  logic        gwe;
  logic        rst_n;
  logic [15:0] imem_addr, imem_data;
  logic [15:0] dmem_addr, dmem_wdata, dmem_rdata;
  logic        dmem_we;
  logic        wb_we;
  logic [2:0]  wb_sel;
  logic [15:0] wb_data;

  logic [15:0] imem [0:65535];
  logic [15:0] dmem [0:65535];
  logic [19:0] got_wr [$];  // {sel, data} seen on the trace
  logic [31:0] got_st [$];  // {addr, data} seen on the data port
  int          low_ticks;   // Cycles with reset already low
  int          cur_test, test_errs, n_errors, n_pass, n_fail;

  lc4_core #(.P_RESET_PC(RESET_PC)) u_lc4_core (
    .gwe(gwe), .i_rst_n(rst_n),
    .o_imem_addr(imem_addr), .i_imem_data(imem_data),
    .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we), .o_dmem_wdata(dmem_wdata),
    .i_dmem_rdata(dmem_rdata),
    .o_wb_we(wb_we), .o_wb_sel(wb_sel), .o_wb_data(wb_data)
  );

  assign imem_data  = imem[imem_addr];  // Same-cycle fetch
  assign dmem_rdata = dmem[dmem_addr];

  always #2 gwe = ~gwe;

  // One clock cycle, outputs sampled mid-cycle, return 1 ns after the edge
  task automatic tick();
    @(negedge gwe);
    if (rst_n) begin
      if (wb_we) got_wr.push_back({1'b0, wb_sel, wb_data});
      if (dmem_we) begin
        dmem[dmem_addr] = dmem_wdata;  // Commits at the end of the cycle
        got_st.push_back({dmem_addr, dmem_wdata});
      end
      low_ticks = 0;
    end else begin
      // Pipeline may still show a write in the first reset cycle
      if (low_ticks > 0 && (wb_we || dmem_we)) begin
        $display("test %0d: a write came out while reset was held low at %0t",
                 cur_test, $time);
        test_errs++;
      end
      low_ticks++;
    end
    @(posedge gwe);
    #1;
  endtask

  task automatic load_memories(input int t);
    for (int a = 0; a < 65536; a++) begin
      imem[16'(a)] = 16'h0000;           // NOP
      dmem[16'(a)] = 16'(a) ^ 16'hC3A5;  // Every address bit shows
    end
    for (int i = 0; i < MAX_PROG; i++) imem[RESET_PC + 16'(i)] = PROG[t][i];
    for (int i = 0; i < N_INIT[t]; i++) dmem[INIT[t][i][31:16]] = INIT[t][i][15:0];
  endtask

  task automatic hold_reset();
    rst_n = 1'b0;
    repeat (RESET_CYCLES) tick();
    rst_n = 1'b1;
    got_wr.delete();
    got_st.delete();
  endtask

  task automatic wait_writes(input int count);
    int cycles;
    cycles = 0;
    while (got_wr.size() < count && cycles < WAIT_LIMIT) begin
      tick();
      cycles++;
    end
    if (got_wr.size() < count) begin
      $display("test %0d: timed out after %0d cycles with %0d of %0d writes seen",
               cur_test, cycles, got_wr.size(), count);
      test_errs++;
    end
  endtask

  task automatic check_results(input int t);
    logic [19:0] exp_wr;
    logic [31:0] exp_st;
    if (got_wr.size() != N_WR[t]) begin
      $display("** Error at %0t: test %0d saw %0d register writes, expected %0d",
               $time, t, got_wr.size(), N_WR[t]);
      test_errs++;
    end
    for (int i = 0; i < N_WR[t] && i < got_wr.size(); i++) begin
      exp_wr = WR[t][i];
      if (got_wr[i] != exp_wr) begin
        $display("** Error at %0t: test %0d write %0d expected r%0d=%h, got r%0d=%h",
                 $time, t, i, exp_wr[18:16], exp_wr[15:0], got_wr[i][18:16], got_wr[i][15:0]);
        test_errs++;
      end
    end
    if (got_st.size() != N_ST[t]) begin
      $display("** Error at %0t: test %0d saw %0d stores, expected %0d",
               $time, t, got_st.size(), N_ST[t]);
      test_errs++;
    end
    for (int i = 0; i < N_ST[t] && i < got_st.size(); i++) begin
      exp_st = ST[t][i];
      if (got_st[i] != exp_st) begin
        $display("** Error at %0t: test %0d store %0d expected %h at %h, got %h at %h",
                 $time, t, i, exp_st[15:0], exp_st[31:16], got_st[i][15:0], got_st[i][31:16]);
        test_errs++;
      end
    end
  endtask

  task automatic run_test(input int t);
    cur_test  = t;
    test_errs = 0;
    load_memories(t);
    hold_reset();
    if (RESET_AFTER[t] > 0) begin  // Cut in mid-program, then start over
      wait_writes(RESET_AFTER[t]);
      hold_reset();
    end
    wait_writes(N_WR[t]);
    repeat (DRAIN_CYCLES) tick();
    check_results(t);
    if (test_errs == 0) begin
      $display("test %0d ok, %0d writes and %0d stores matched", t, N_WR[t], N_ST[t]);
      n_pass++;
    end else begin
      $display("test %0d failed with %0d errors", t, test_errs);
      n_fail++;
    end
    n_errors += test_errs;
  endtask

  initial begin
    gwe       = 1'b0;
    rst_n     = 1'b0;
    low_ticks = 0;
    n_errors  = 0;
    n_pass    = 0;
    n_fail    = 0;
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("tests %0d, ok %0d, failed %0d, errors %0d", NUM_TESTS, n_pass, n_fail, n_errors);
    if (n_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
